/* hw/mac_pkg.sv */
`default_nettype none

package mac_pkg;

  // Base widths
  localparam int mac_min_width  = 8;   // One operand byte
  localparam int mac_op_width   = 32;
  localparam int mac_int_width  = 40;  // 32x8 row product
  localparam int mac_prod_width = 64;  // Widest lane product, quad mode
  localparam int mac_acc_width  = 80;

  // Lane accumulator slots, product bits plus guard bits
  localparam int acc_lane_single = 20; // 16 + 4
  localparam int acc_lane_dual   = 40; // 32 + 8
  localparam int acc_lane_quad   = 80; // 64 + 16

  typedef logic [mac_min_width-1:0]  byte_t;
  typedef logic [mac_op_width-1:0]   op_t;
  typedef logic [mac_int_width-1:0]  row_t;
  typedef logic [mac_prod_width-1:0] prod_t;  // Lanes in 16, 32 or 64 bit slots
  typedef logic [mac_acc_width-1:0]  acc_t;   // Lanes in 20, 40 or 80 bit slots

  // Precision mode, value 3 is not a legal mode
  typedef enum logic [1:0] {
    cfg_single = 2'd0,  // Four 8x8 lanes
    cfg_dual   = 2'd1,  // Two 16x16 lanes
    cfg_quad   = 2'd2   // One 32x32 lane
  } mac_cfg_e;

endpackage

`default_nettype wire

/* hw/multiply.sv */
`timescale 1ns/1ns
`default_nettype none

module multiply (
  input  mac_pkg::byte_t                     a,
  input  mac_pkg::byte_t                     b,
  output logic [2*mac_pkg::mac_min_width-1:0] c
);
  import mac_pkg::*;

  // Shift-and-add over the bits of b, one partial-product row per bit
  always_comb begin
    c = '0;
    for (int i = 0; i < mac_min_width; i++) begin
      if (b[i])
        c = c + ((2*mac_min_width)'(a) << i);
    end
  end

endmodule

`default_nettype wire

/* hw/n_bit_cla_adder.sv */
`timescale 1ns/1ns
`default_nettype none

module n_bit_cla_adder #(
  parameter int n = 8
) (
  input  logic [n-1:0] a,
  input  logic [n-1:0] b,
  input  logic         cin,
  output logic [n-1:0] sum,
  output logic         cout
);

  logic [n-1:0] g;  // Generate
  logic [n-1:0] p;  // Propagate
  logic [n:0]   c;

  assign g = a & b;
  assign p = a ^ b;

  // Every carry is a flat sum of products of g, p and cin,
  // so no carry waits on the one below it
  always_comb begin : lookahead
    logic carry;
    logic prop;
    c[0] = cin;
    for (int i = 0; i < n; i++) begin
      carry = g[i];
      prop  = p[i];
      for (int j = i - 1; j >= 0; j--) begin
        carry = carry | (prop & g[j]);
        prop  = prop & p[j];
      end
      c[i+1] = carry | (prop & cin);
    end
  end

  assign sum  = p ^ c[n-1:0];
  assign cout = c[n];

endmodule

`default_nettype wire

/* hw/mac_mul_block.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_mul_block #(
  parameter int blk_idx = 0  // Byte of B served by this row
) (
  input  mac_pkg::byte_t   b,
  input  mac_pkg::byte_t   a0,
  input  mac_pkg::byte_t   a1,
  input  mac_pkg::byte_t   a2,
  input  mac_pkg::byte_t   a3,
  input  mac_pkg::mac_cfg_e cfg,
  output mac_pkg::row_t    row
);
  import mac_pkg::*;

  localparam bit upper_pair = (blk_idx >= 2);  // Dual lane 1 uses a3:a2

  logic [2*mac_min_width-1:0] p [4];  // Byte products ak*b
  byte_t s1, s2, s3, s4;
  logic  c1, c2, c3;
  byte_t add2_b;
  logic  add3_cin;

  multiply u_mul0 (.a(a0), .b(b), .c(p[0]));
  multiply u_mul1 (.a(a1), .b(b), .c(p[1]));
  multiply u_mul2 (.a(a2), .b(b), .c(p[2]));
  multiply u_mul3 (.a(a3), .b(b), .c(p[3]));

  // Outside quad the a1/a2 boundary is a lane edge
  assign add2_b   = (cfg == cfg_quad) ? p[2][mac_min_width-1:0] : '0;
  assign add3_cin = (cfg == cfg_quad) ? c2 : 1'b0;  // Carry cut for dual

  n_bit_cla_adder #(.n(mac_min_width)) u_add1 (
    .a(p[0][2*mac_min_width-1:mac_min_width]), .b(p[1][mac_min_width-1:0]),
    .cin(1'b0), .sum(s1), .cout(c1)
  );

  n_bit_cla_adder #(.n(mac_min_width)) u_add2 (
    .a(p[1][2*mac_min_width-1:mac_min_width]), .b(add2_b),
    .cin(c1), .sum(s2), .cout(c2)
  );

  n_bit_cla_adder #(.n(mac_min_width)) u_add3 (
    .a(p[2][2*mac_min_width-1:mac_min_width]), .b(p[3][mac_min_width-1:0]),
    .cin(add3_cin), .sum(s3), .cout(c3)
  );

  // Top byte of a 32x8 product never carries out
  n_bit_cla_adder #(.n(mac_min_width)) u_add4 (
    .a(p[3][2*mac_min_width-1:mac_min_width]), .b('0),
    .cin(c3), .sum(s4), .cout()
  );

  always_comb begin
    case (cfg)
      cfg_quad: row = {s4, s3, s2, s1, p[0][mac_min_width-1:0]};
      cfg_dual: begin
        if (upper_pair)
          row = {16'b0, s4, s3, p[2][mac_min_width-1:0]};
        else
          row = {16'b0, s2, s1, p[0][mac_min_width-1:0]};
      end
      cfg_single: row = {24'b0, p[blk_idx]};
      default:    row = '0;
    endcase
  end

  // A single-mode row is one 8x8 product
  always_comb begin
    if (cfg == cfg_single) begin
      assert final (row[mac_int_width-1:2*mac_min_width] == '0)
        else $error("mac_mul_block %0d: single row wider than 16 bits", blk_idx);
    end
  end

endmodule

`default_nettype wire

/* hw/mac_pp_combine.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_pp_combine (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              clr,
  input  mac_pkg::mac_cfg_e cfg,
  input  mac_pkg::row_t     row0,
  input  mac_pkg::row_t     row1,
  input  mac_pkg::row_t     row2,
  input  mac_pkg::row_t     row3,
  output mac_pkg::prod_t    prod,
  output mac_pkg::mac_cfg_e prod_cfg,
  output logic              prod_clr,
  output logic              prod_valid
);
  import mac_pkg::*;

  localparam int dual_w   = 2 * 2 * mac_min_width;  // 16x16 lane product
  localparam int single_w = 2 * mac_min_width;

  logic [dual_w-1:0] dual_lo, dual_hi;
  prod_t             quad_sum;
  prod_t             sum;

  // Row k is already aligned to byte k of B
  assign dual_lo = dual_w'(row0) + (dual_w'(row1) << mac_min_width);
  assign dual_hi = dual_w'(row2) + (dual_w'(row3) << mac_min_width);

  assign quad_sum = prod_t'(row0)
                  + (prod_t'(row1) << mac_min_width)
                  + (prod_t'(row2) << (2*mac_min_width))
                  + (prod_t'(row3) << (3*mac_min_width));

  always_comb begin
    case (cfg)
      cfg_single: sum = {row3[single_w-1:0], row2[single_w-1:0],
                         row1[single_w-1:0], row0[single_w-1:0]};
      cfg_dual:   sum = {dual_hi, dual_lo};
      cfg_quad:   sum = quad_sum;
      default:    sum = '0;
    endcase
  end

  // Stage 1 register
  always_ff @(posedge clk) begin
    if (en) begin
      prod     <= sum;
      prod_cfg <= cfg;  // Travels with its product
      prod_clr <= clr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      prod_valid <= 1'b0;
    else
      prod_valid <= en;
  end

endmodule

`default_nettype wire

/* hw/mac_accum.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_accum (
  input  logic              clk,
  input  logic              rst_n,
  input  mac_pkg::prod_t    prod,
  input  mac_pkg::mac_cfg_e prod_cfg,
  input  logic              prod_clr,
  input  logic              prod_valid,
  output mac_pkg::acc_t     acc,
  output logic              acc_valid
);
  import mac_pkg::*;

  localparam int single_lanes = mac_acc_width / acc_lane_single;
  localparam int dual_lanes   = mac_acc_width / acc_lane_dual;
  localparam int single_prod  = mac_prod_width / single_lanes;  // 16
  localparam int dual_prod    = mac_prod_width / dual_lanes;    // 32

  acc_t acc_next;

  // Each slot wraps on its own so no carry crosses a lane
  always_comb begin
    acc_next = acc;
    case (prod_cfg)
      cfg_single: begin
        for (int k = 0; k < single_lanes; k++) begin
          acc_next[k*acc_lane_single +: acc_lane_single] =
            (prod_clr ? '0 : acc[k*acc_lane_single +: acc_lane_single])
            + acc_lane_single'(prod[k*single_prod +: single_prod]);
        end
      end
      cfg_dual: begin
        for (int k = 0; k < dual_lanes; k++) begin
          acc_next[k*acc_lane_dual +: acc_lane_dual] =
            (prod_clr ? '0 : acc[k*acc_lane_dual +: acc_lane_dual])
            + acc_lane_dual'(prod[k*dual_prod +: dual_prod]);
        end
      end
      cfg_quad:
        acc_next = (prod_clr ? '0 : acc) + acc_lane_quad'(prod);
      default: acc_next = acc;  // Illegal mode leaves the state alone
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc       <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= prod_valid;
      if (prod_valid)
        acc <= acc_next;
    end
  end

  a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    acc_valid == $past(prod_valid))
    else $error("acc_valid does not trail prod_valid by one cycle");

endmodule

`default_nettype wire

/* hw/mac_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              clr,
  input  mac_pkg::mac_cfg_e cfg,
  input  mac_pkg::op_t      a,
  input  mac_pkg::op_t      b,
  output mac_pkg::acc_t     acc,
  output logic              acc_valid
);
  import mac_pkg::*;

  row_t     row [4];
  prod_t    prod;
  mac_cfg_e prod_cfg;
  logic     prod_clr;
  logic     prod_valid;

  // One row per byte of B and each row sees the whole of A
  for (genvar k = 0; k < 4; k++) begin : g_row
    mac_mul_block #(.blk_idx(k)) u_mul_block (
      .b  (b[k*mac_min_width +: mac_min_width]),
      .a0 (a[0*mac_min_width +: mac_min_width]),
      .a1 (a[1*mac_min_width +: mac_min_width]),
      .a2 (a[2*mac_min_width +: mac_min_width]),
      .a3 (a[3*mac_min_width +: mac_min_width]),
      .cfg(cfg),
      .row(row[k])
    );
  end

  mac_pp_combine u_pp_combine (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .clr       (clr),
    .cfg       (cfg),
    .row0      (row[0]),
    .row1      (row[1]),
    .row2      (row[2]),
    .row3      (row[3]),
    .prod      (prod),
    .prod_cfg  (prod_cfg),
    .prod_clr  (prod_clr),
    .prod_valid(prod_valid)
  );

  mac_accum u_accum (
    .clk       (clk),
    .rst_n     (rst_n),
    .prod      (prod),
    .prod_cfg  (prod_cfg),
    .prod_clr  (prod_clr),
    .prod_valid(prod_valid),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

  a_cfg_legal: assert property (@(posedge clk) disable iff (!rst_n)
    en |-> cfg inside {cfg_single, cfg_dual, cfg_quad})
    else $error("illegal cfg %0d with en high", cfg);

endmodule

`default_nettype wire

/* bench/mac_model.svh */
`ifndef mac_model_svh
`define mac_model_svh

// Product of lane k whose operands are the ow-bit fields at ow*k of a and b
function automatic acc_t lane_product(int ow, op_t a, op_t b, int k);
  acc_t mask;
  mask = (acc_t'(1) << ow) - 1;
  return ((acc_t'(a) >> (ow*k)) & mask) * ((acc_t'(b) >> (ow*k)) & mask);
endfunction

// Loads or adds one operation per lane and wraps each slot on its own
function automatic acc_t accumulate(acc_t old, mac_cfg_e mode, logic clear, op_t a, op_t b);
  int   lanes;
  int   sw;
  acc_t mask;
  acc_t lane_sum;
  acc_t nxt;
  lanes = (mode == cfg_single) ? 4 : (mode == cfg_dual) ? 2 : 1;
  sw    = mac_acc_width / lanes;  // Product bits plus guard bits
  mask  = (sw == mac_acc_width) ? '1 : (acc_t'(1) << sw) - 1;
  nxt   = '0;
  for (int k = 0; k < lanes; k++) begin
    lane_sum = clear ? '0 : (old >> (sw*k)) & mask;
    lane_sum = (lane_sum + lane_product(mac_op_width / lanes, a, b, k)) & mask;
    nxt      = nxt | (lane_sum << (sw*k));
  end
  return nxt;
endfunction

`endif

/* bench/tb_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mac;
  import mac_pkg::*;

  `include "mac_model.svh"

  localparam int ops_per_test = 400;
  // Four tests at no more than five cycles per operation plus reset and drain
  localparam int cycle_limit  = 4 * 5 * ops_per_test + 100;
  localparam int latency      = 2;  // Issue cycle to acc_valid cycle

  logic     clk;
  logic     rst_n;
  logic     en;
  logic     clr;
  mac_cfg_e cfg;
  op_t      a;
  op_t      b;
  acc_t     acc;
  logic     acc_valid;

  // Operations in flight with the oldest at the front
  mac_cfg_e q_cfg [$];
  logic     q_clr [$];
  op_t      q_a [$];
  op_t      q_b [$];
  int       q_cyc [$];

  acc_t  model_acc = '0;
  int    cyc       = 0;
  int    issued    = 0;
  int    pulses    = 0;
  string test_name = "reset";

  mac_top u_mac_top (
    .clk(clk), .rst_n(rst_n), .en(en), .clr(clr), .cfg(cfg),
    .a(a), .b(b), .acc(acc), .acc_valid(acc_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_acc(string name, acc_t expected, acc_t actual);
    if (actual !== expected)
      fail_run($sformatf("ERR %s: expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_valid(string name, int expected, int actual);
    if (actual != expected)
      fail_run($sformatf("ERR %s: expected %0d pulses actual %0d", name, expected, actual));
  endtask

  task automatic check_delay(string name, int expected, int actual);
    if (actual != expected)
      fail_run($sformatf("ERR %s: expected delay %0d actual %0d", name, expected, actual));
  endtask

  // Outputs are sampled mid-cycle away from the clock edge and the drive time
  always @(negedge clk) begin
    cyc++;
    if (cyc > cycle_limit) begin
      fail_run($sformatf("Timeout: run still busy after %0d cycles", cycle_limit));
    end else begin
      if (acc_valid === 1'b1) begin
        pulses++;
        if (q_cyc.size() == 0) begin
          fail_run("acc_valid pulsed with no operation in flight");
        end else begin
          check_delay(test_name, latency, cyc - q_cyc[0]);
          model_acc = accumulate(model_acc, q_cfg[0], q_clr[0], q_a[0], q_b[0]);
          check_acc(test_name, model_acc, acc);
          void'(q_cfg.pop_front());
          void'(q_clr.pop_front());
          void'(q_a.pop_front());
          void'(q_b.pop_front());
          void'(q_cyc.pop_front());
        end
      end
      if (rst_n && en) begin
        q_cfg.push_back(cfg);
        q_clr.push_back(clr);
        q_a.push_back(a);
        q_b.push_back(b);
        q_cyc.push_back(cyc);
        issued++;
      end
    end
  end

  task automatic issue(mac_cfg_e mode, logic clear, op_t op_a, op_t op_b);
    @(posedge clk);
    #1;
    en  = 1'b1;
    cfg = mode;
    clr = clear;
    a   = op_a;
    b   = op_b;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      en  = 1'b0;
      clr = 1'b0;
    end
  endtask

  task automatic wait_drain();
    while (q_cyc.size() != 0)
      @(posedge clk);
  endtask

  // Half the operations go back to back
  function automatic int pick_gap();
    return ($urandom % 2) ? 0 : $urandom_range(3, 1);
  endfunction

  function automatic op_t pick_operand(bit extreme);
    op_t v;
    v = $urandom;
    if (extreme) begin
      case ($urandom % 4)
        0:       v = '1;
        1:       v = '0;
        2:       v = op_t'(1) << ($urandom % 32);
        default: v = $urandom;
      endcase
    end
    return v;
  endfunction

  // Only the first operation clears so the lanes wrap through their guard bits
  task automatic run_fixed_mode(string name, mac_cfg_e mode, bit extreme);
    test_name = name;
    for (int i = 0; i < ops_per_test; i++) begin
      issue(mode, i == 0, pick_operand(extreme), pick_operand(extreme));
      idle(pick_gap());
    end
    idle(1);
    wait_drain();
  endtask

  task automatic run_mode_switch(string name);
    mac_cfg_e mode;
    mac_cfg_e next_mode;
    logic     clear;
    test_name = name;
    mode      = cfg_quad;
    for (int i = 0; i < ops_per_test; i++) begin
      next_mode = mode;
      if (i == 0 || $urandom % 8 == 0)
        next_mode = mac_cfg_e'($urandom_range(2, 0));
      clear = (next_mode != mode) || (i == 0) || ($urandom % 16 == 0);  // Load on mode change
      mode  = next_mode;
      issue(mode, clear, pick_operand(1'b1), pick_operand(1'b0));
      idle(pick_gap());
    end
    idle(1);
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'h9c4));
    rst_n = 1'b0;
    en    = 1'b0;
    clr   = 1'b0;
    cfg   = cfg_single;
    a     = '0;
    b     = '0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_valid("reset", 0, pulses);
    check_acc("reset", '0, acc);
    run_fixed_mode("single_wrap", cfg_single, 1'b0);
    run_fixed_mode("dual_lanes", cfg_dual, 1'b0);
    run_fixed_mode("quad_extreme", cfg_quad, 1'b1);
    run_mode_switch("clear_switch");
    idle(4);
    check_valid("strobe_count", issued, pulses);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/mac_pkg.sv
hw/multiply.sv
hw/n_bit_cla_adder.sv
hw/mac_mul_block.sv
hw/mac_pp_combine.sv
hw/mac_accum.sv
hw/mac_top.sv
bench/tb_mac.sv
+incdir+bench

/* Makefile */
SIM := obj_dir/tb_mac

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_mac -Mdir obj_dir -o tb_mac

run: compile
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
